/* logic/rv_isa_pkg.sv */
// RV32I instruction encodings, format views and architectural widths
package rv_isa_pkg;

  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;

  // Major opcodes
  localparam logic [6:0] OPC_LOAD    = 7'b0000011;
  localparam logic [6:0] OPC_MISCMEM = 7'b0001111;
  localparam logic [6:0] OPC_OPIMM   = 7'b0010011;
  localparam logic [6:0] OPC_AUIPC   = 7'b0010111;
  localparam logic [6:0] OPC_STORE   = 7'b0100011;
  localparam logic [6:0] OPC_OP      = 7'b0110011;
  localparam logic [6:0] OPC_LUI     = 7'b0110111;
  localparam logic [6:0] OPC_JAL     = 7'b1101111;
  localparam logic [6:0] OPC_SYSTEM  = 7'b1110011;

  localparam logic [2:0] FUNCT3_SLL = 3'b001;
  localparam logic [2:0] FUNCT3_SRL = 3'b101; // Also SRA, told apart by bit 30

  ////////////////////
  // Format views of one instruction word
  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]           imm;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]            imm_hi;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [4:0]            imm_lo;
    logic [6:0]            opcode;
  } s_fmt_t;

  typedef struct packed {
    logic [19:0]           imm;   // Upper 20 bits of the result
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } u_fmt_t;

  typedef struct packed {
    logic                  imm20;
    logic [9:0]            imm10_1;
    logic                  imm11;
    logic [7:0]            imm19_12;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } instr_t;

endpackage

/* logic/decoder_pkg.sv */
// Decoder microarchitecture: control bundles, FSM states and sequence constants
package decoder_pkg;
  import rv_isa_pkg::*;

  localparam int unsigned ALU_SEL_W  = 4;
  localparam int unsigned LSU_CTRL_W = 4;  // Opcode bit 5 followed by funct3
  localparam int unsigned WAIT_CNT_W = 2;

  localparam logic [ALU_SEL_W-1:0]  ALU_ADD          = 4'b0000;
  localparam logic [WAIT_CNT_W-1:0] LOAD_WAIT_CYCLES = 2'd3;
  localparam logic [WAIT_CNT_W-1:0] JAL_WAIT_CYCLES  = 2'd2;
  localparam logic [XLEN-1:0]       JAL_LINK_OFFSET  = 32'd4;

  ////////////////////
  // Control bundles
  typedef struct packed {
    logic                  alu_write; // Write port belongs to the ALU
    logic [ALU_SEL_W-1:0]  sel;
    logic                  op_a;      // Operand A read from the register file
    logic                  op_b;
    logic                  use_pc;    // PC replaces operand A
    logic [REG_ADDR_W-1:0] dest;
    logic                  wb;
    logic                  is_imm;
    logic [XLEN-1:0]       imm;
  } alu_ctrl_t;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] addr_a;
    logic [REG_ADDR_W-1:0] addr_b;
  } rf_req_t;

  typedef struct packed {
    logic                  valid;
    logic [LSU_CTRL_W-1:0] ctrl;
    logic [REG_ADDR_W-1:0] regdest;
  } lsu_ctrl_t;

  typedef struct packed {
    alu_ctrl_t alu;
    rf_req_t   rf;
    lsu_ctrl_t lsu;
    logic      illegal;
  } dec_ctrl_t;

  typedef enum logic [2:0] {
    IMM_I, IMM_SHAMT, IMM_S, IMM_U, IMM_J, IMM_LINK
  } imm_sel_e;

  typedef enum logic [2:0] {
    S_IDLE, S_STALLED, S_LOAD_ISSUE, S_LOAD_WAIT, S_STORE_ISSUE, S_JAL_WAIT
  } fsm_state_e;

endpackage

/* logic/imm_gen.sv */
// Immediate generator, extends the selected instruction immediate to XLEN bits
`timescale 1ns/1ps

module imm_gen
  import rv_isa_pkg::*;
  import decoder_pkg::*;
(
  input  instr_t          instr_i,
  input  imm_sel_e        imm_sel_i,
  output logic [XLEN-1:0] imm_o
);

  always_comb begin
    case (imm_sel_i)
      IMM_I: begin
        imm_o = {{20{instr_i.i_fmt.imm[11]}}, instr_i.i_fmt.imm};
      end
      IMM_SHAMT: begin
        imm_o = {{(XLEN-REG_ADDR_W){1'b0}}, instr_i.r_fmt.rs2}; // Shift amount, no sign
      end
      IMM_S: begin
        imm_o = {{20{instr_i.s_fmt.imm_hi[6]}}, instr_i.s_fmt.imm_hi, instr_i.s_fmt.imm_lo};
      end
      IMM_U: begin
        imm_o = {instr_i.u_fmt.imm, 12'b0};
      end
      IMM_J: begin
        // Scrambled 21 bit offset, bit 0 always zero
        imm_o = {{11{instr_i.j_fmt.imm20}}, instr_i.j_fmt.imm20, instr_i.j_fmt.imm19_12,
                 instr_i.j_fmt.imm11, instr_i.j_fmt.imm10_1, 1'b0};
      end
      IMM_LINK: begin
        imm_o = JAL_LINK_OFFSET;
      end
      default: begin
        imm_o = '0;
      end
    endcase
  end

endmodule

/* logic/hazard_unit.sv */
// Read-after-write detector against the destination of the last issued instruction
`timescale 1ns/1ps

module hazard_unit
  import rv_isa_pkg::*;
(
  input  logic   clk_i,
  input  logic   rstn_i,
  input  instr_t instr_i,
  input  logic   issue_i,      // First execute cycle of an accepted instruction
  output logic   raw_hazard_o
);

  logic [REG_ADDR_W-1:0] last_rd_q;
  logic                  writes_rd;
  logic                  reads_rs1;
  logic                  reads_rs2;

  // Which register fields the current opcode really uses
  always_comb begin
    writes_rd = 1'b0;
    reads_rs1 = 1'b0;
    reads_rs2 = 1'b0;
    case (instr_i.r_fmt.opcode)
      OPC_LOAD: begin
        writes_rd = 1'b1;
        reads_rs1 = 1'b1;
      end
      OPC_OPIMM: begin
        writes_rd = 1'b1;
        reads_rs1 = 1'b1;
      end
      OPC_OP: begin
        writes_rd = 1'b1;
        reads_rs1 = 1'b1;
        reads_rs2 = 1'b1;
      end
      OPC_STORE: begin
        reads_rs1 = 1'b1;
        reads_rs2 = 1'b1;
      end
      OPC_LUI, OPC_AUIPC, OPC_JAL: writes_rd = 1'b1;
      default: writes_rd = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      last_rd_q <= '0;
    end else if (issue_i) begin
      last_rd_q <= writes_rd ? instr_i.r_fmt.rd : '0; // x0 never matches below
    end
  end

  assign raw_hazard_o = (reads_rs1 && (instr_i.r_fmt.rs1 != '0) && (instr_i.r_fmt.rs1 == last_rd_q)) ||
                        (reads_rs2 && (instr_i.r_fmt.rs2 != '0) && (instr_i.r_fmt.rs2 == last_rd_q));

endmodule

/* logic/wait_timer.sv */
// Loadable down-counter timing the load and jump wait phases
`timescale 1ns/1ps

module wait_timer
  import decoder_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rstn_i,
  input  logic                  load_i,
  input  logic [WAIT_CNT_W-1:0] count_i,
  output logic                  done_o
);

  logic [WAIT_CNT_W-1:0] cnt_q;

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= count_i;
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - WAIT_CNT_W'(1); // Holds at zero when idle
    end
  end

  assign done_o = (cnt_q == WAIT_CNT_W'(1)); // Last counted cycle

endmodule

/* logic/decode_fsm.sv */
// Instruction sequencing FSM with combinational control decode
`timescale 1ns/1ps

module decode_fsm
  import rv_isa_pkg::*;
  import decoder_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rstn_i,
  input  instr_t                instr_i,
  input  logic [XLEN-1:0]       pc_i,
  input  logic                  instr_valid_i,
  input  logic [XLEN-1:0]       imm_i,
  input  logic                  raw_hazard_i,
  input  logic                  timer_done_i,
  output imm_sel_e              imm_sel_o,
  output logic                  issue_o,
  output logic                  timer_load_o,
  output logic [WAIT_CNT_W-1:0] timer_count_o,
  output dec_ctrl_t             ctrl_o,
  output logic                  ready_o,      // Fetch may advance
  output logic                  jmp_o,
  output logic [XLEN-1:0]       jmp_addr_o
);

  fsm_state_e state_q;
  fsm_state_e state_d;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       is_shift;

  assign opcode   = instr_i.r_fmt.opcode;
  assign funct3   = instr_i.r_fmt.funct3;
  assign is_shift = (funct3 == FUNCT3_SLL) || (funct3 == FUNCT3_SRL);

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////
  // Next state and control
  always_comb begin
    state_d       = S_IDLE;
    ctrl_o        = '0;
    imm_sel_o     = IMM_I;
    issue_o       = 1'b0;
    timer_load_o  = 1'b0;
    timer_count_o = '0;
    ready_o       = 1'b0;
    jmp_o         = 1'b0;
    jmp_addr_o    = '0;

    if (!instr_valid_i) begin
      ready_o = 1'b1;              // Nothing to hold, back to idle
    end else if ((state_q == S_IDLE) && raw_hazard_i) begin
      state_d = S_STALLED;         // One bubble, writeback stays off
    end else begin
      case (state_q)
        S_IDLE, S_STALLED: begin
          issue_o = 1'b1;
          ready_o = 1'b1;
          case (opcode)
            OPC_OP: begin
              ctrl_o.alu.alu_write = 1'b1;
              ctrl_o.alu.sel       = {instr_i.r_fmt.funct7[5], funct3};
              ctrl_o.alu.op_a      = 1'b1;
              ctrl_o.alu.op_b      = 1'b1;
              ctrl_o.alu.dest      = instr_i.r_fmt.rd;
              ctrl_o.alu.wb        = 1'b1;
              ctrl_o.rf.addr_a     = instr_i.r_fmt.rs1;
              ctrl_o.rf.addr_b     = instr_i.r_fmt.rs2;
            end
            OPC_OPIMM: begin
              imm_sel_o            = is_shift ? IMM_SHAMT : IMM_I;
              ctrl_o.alu.alu_write = 1'b1;
              ctrl_o.alu.sel       = {is_shift & instr_i.r_fmt.funct7[5], funct3};
              ctrl_o.alu.op_a      = 1'b1;
              ctrl_o.alu.dest      = instr_i.r_fmt.rd;
              ctrl_o.alu.wb        = 1'b1;
              ctrl_o.alu.imm       = imm_i;
              ctrl_o.rf.addr_a     = instr_i.r_fmt.rs1;
            end
            OPC_LUI, OPC_AUIPC: begin
              imm_sel_o            = IMM_U;
              ctrl_o.alu.alu_write = 1'b1;
              ctrl_o.alu.sel       = ALU_ADD;
              ctrl_o.alu.op_a      = 1'b1;    // x0 for LUI, PC for AUIPC
              ctrl_o.alu.use_pc    = (opcode == OPC_AUIPC);
              ctrl_o.alu.dest      = instr_i.r_fmt.rd;
              ctrl_o.alu.wb        = 1'b1;
              ctrl_o.alu.imm       = imm_i;
            end
            OPC_JAL: begin
              imm_sel_o            = IMM_J;
              jmp_o                = 1'b1;
              jmp_addr_o           = pc_i + imm_i;
              ctrl_o.alu.alu_write = 1'b1;
              ctrl_o.alu.sel       = ALU_ADD;
              ctrl_o.alu.use_pc    = 1'b1;    // Link is PC + 4
              ctrl_o.alu.dest      = instr_i.r_fmt.rd;
              ctrl_o.alu.wb        = 1'b1;
              ctrl_o.alu.imm       = JAL_LINK_OFFSET;
              timer_load_o         = 1'b1;
              timer_count_o        = JAL_WAIT_CYCLES;
              ready_o              = 1'b0;
              state_d              = S_JAL_WAIT;
            end
            OPC_LOAD, OPC_STORE: begin
              // Address calculation cycle
              imm_sel_o        = (opcode == OPC_LOAD) ? IMM_I : IMM_S;
              ctrl_o.alu.sel   = ALU_ADD;
              ctrl_o.alu.op_a  = 1'b1;
              ctrl_o.alu.imm   = imm_i;
              ctrl_o.rf.addr_a = instr_i.r_fmt.rs1;
              ctrl_o.rf.addr_b = (opcode == OPC_STORE) ? instr_i.r_fmt.rs2 : '0;
              ready_o          = 1'b0;
              state_d          = (opcode == OPC_LOAD) ? S_LOAD_ISSUE : S_STORE_ISSUE;
            end
            OPC_MISCMEM, OPC_SYSTEM: ready_o = 1'b1; // Treated as no-ops
            default: ctrl_o.illegal = 1'b1;
          endcase
        end
        S_LOAD_ISSUE: begin
          ctrl_o.alu.sel     = ALU_ADD;
          ctrl_o.rf.addr_a   = instr_i.r_fmt.rs1;
          ctrl_o.lsu.valid   = 1'b1;
          ctrl_o.lsu.ctrl    = {opcode[5], funct3};
          ctrl_o.lsu.regdest = instr_i.r_fmt.rd;
          timer_load_o       = 1'b1;
          timer_count_o      = LOAD_WAIT_CYCLES;
          state_d            = S_LOAD_WAIT;
        end
        S_LOAD_WAIT: begin
          ctrl_o.alu.sel   = ALU_ADD;
          ctrl_o.rf.addr_a = instr_i.r_fmt.rs1;
          ready_o          = timer_done_i;
          state_d          = timer_done_i ? S_IDLE : S_LOAD_WAIT;
        end
        S_STORE_ISSUE: begin
          ctrl_o.alu.sel   = ALU_ADD;
          ctrl_o.alu.op_b  = 1'b1;            // Store data from rs2
          ctrl_o.rf.addr_a = instr_i.r_fmt.rs1;
          ctrl_o.rf.addr_b = instr_i.r_fmt.rs2;
          ctrl_o.lsu.valid = 1'b1;
          ctrl_o.lsu.ctrl  = {opcode[5], funct3};
          ready_o          = 1'b1;
        end
        S_JAL_WAIT: begin
          // Link offset stays on the immediate, writeback already done
          imm_sel_o            = IMM_LINK;
          ctrl_o.alu.alu_write = 1'b1;
          ctrl_o.alu.sel       = ALU_ADD;
          ctrl_o.alu.dest      = instr_i.r_fmt.rd;
          ctrl_o.alu.imm       = imm_i;
          ready_o              = timer_done_i;
          state_d              = timer_done_i ? S_IDLE : S_JAL_WAIT;
        end
        default: ready_o = 1'b1;
      endcase
    end

    ctrl_o.alu.is_imm = ~(ctrl_o.alu.op_a & ctrl_o.alu.op_b);
  end

endmodule

/* logic/issue_regs.sv */
// Output registers for the decoded control, held while no valid instruction is present
`timescale 1ns/1ps

module issue_regs
  import decoder_pkg::*;
(
  input  logic      clk_i,
  input  logic      rstn_i,
  input  logic      instr_valid_i,
  input  dec_ctrl_t ctrl_i,
  output alu_ctrl_t alu_ctrl_o,
  output rf_req_t   rf_req_o,
  output lsu_ctrl_t lsu_ctrl_o,
  output logic      illegal_o
);

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      alu_ctrl_o           <= '0;
      alu_ctrl_o.alu_write <= 1'b1; // ALU owns the write port by default
      rf_req_o             <= '0;
      lsu_ctrl_o           <= '0;
      illegal_o            <= 1'b0;
    end else if (instr_valid_i) begin
      alu_ctrl_o <= ctrl_i.alu;
      rf_req_o   <= ctrl_i.rf;
      lsu_ctrl_o <= ctrl_i.lsu;
      illegal_o  <= ctrl_i.illegal;
    end else begin
      // Hold everything, but PC must not leak into the next operand
      alu_ctrl_o.use_pc <= 1'b0;
    end
  end

endmodule

/* logic/rv32_decoder.sv */
// RV32I decoder top, sequences multi-cycle instructions and registers the control
`timescale 1ns/1ps

module rv32_decoder
  import rv_isa_pkg::*;
  import decoder_pkg::*;
(
  input  logic            clk_i,
  input  logic            rstn_i,
  input  instr_t          instr_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic            instr_valid_i,
  output logic            ready_o,
  output logic            jmp_o,
  output logic [XLEN-1:0] jmp_addr_o,
  output alu_ctrl_t       alu_ctrl_o,
  output rf_req_t         rf_req_o,
  output lsu_ctrl_t       lsu_ctrl_o,
  output logic            illegal_o
);

  imm_sel_e              imm_sel;
  logic [XLEN-1:0]       imm;
  logic                  issue;
  logic                  raw_hazard;
  logic                  timer_load;
  logic [WAIT_CNT_W-1:0] timer_count;
  logic                  timer_done;
  dec_ctrl_t             ctrl;

  imm_gen i_imm_gen (
    .instr_i   (instr_i),
    .imm_sel_i (imm_sel),
    .imm_o     (imm)
  );

  hazard_unit i_hazard_unit (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .instr_i      (instr_i),
    .issue_i      (issue),
    .raw_hazard_o (raw_hazard)
  );

  wait_timer i_wait_timer (
    .clk_i   (clk_i),
    .rstn_i  (rstn_i),
    .load_i  (timer_load),
    .count_i (timer_count),
    .done_o  (timer_done)
  );

  decode_fsm i_decode_fsm (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .instr_valid_i (instr_valid_i),
    .imm_i         (imm),
    .raw_hazard_i  (raw_hazard),
    .timer_done_i  (timer_done),
    .imm_sel_o     (imm_sel),
    .issue_o       (issue),
    .timer_load_o  (timer_load),
    .timer_count_o (timer_count),
    .ctrl_o        (ctrl),
    .ready_o       (ready_o),
    .jmp_o         (jmp_o),
    .jmp_addr_o    (jmp_addr_o)
  );

  issue_regs i_issue_regs (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_valid_i (instr_valid_i),
    .ctrl_i        (ctrl),
    .alu_ctrl_o    (alu_ctrl_o),
    .rf_req_o      (rf_req_o),
    .lsu_ctrl_o    (lsu_ctrl_o),
    .illegal_o     (illegal_o)
  );

endmodule

/* include/tb_checks.svh */
// Testbench helpers, RV32I instruction builders and typed compare tasks for the decoder
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

////////////////////
// Instruction builders, straight from the RV32I encodings

function automatic instr_t build_r(input logic [6:0] funct7, input logic [4:0] rs2,
                                   input logic [4:0] rs1, input logic [2:0] funct3,
                                   input logic [4:0] rd, input logic [6:0] opcode);
  return {funct7, rs2, rs1, funct3, rd, opcode};
endfunction

function automatic instr_t build_i(input logic [11:0] imm, input logic [4:0] rs1,
                                   input logic [2:0] funct3, input logic [4:0] rd,
                                   input logic [6:0] opcode);
  return {imm, rs1, funct3, rd, opcode};
endfunction

function automatic instr_t build_s(input logic [11:0] imm, input logic [4:0] rs2,
                                   input logic [4:0] rs1, input logic [2:0] funct3);
  return {imm[11:5], rs2, rs1, funct3, imm[4:0], OPC_STORE};
endfunction

function automatic instr_t build_u(input logic [19:0] imm, input logic [4:0] rd,
                                   input logic [6:0] opcode);
  return {imm, rd, opcode};
endfunction

// Offset bit 0 is dropped by the format
function automatic instr_t build_j(input logic [20:0] offset, input logic [4:0] rd);
  return {offset[20], offset[10:1], offset[11], offset[19:12], rd, OPC_JAL};
endfunction

function automatic logic [31:0] sext12(input logic [11:0] imm);
  return {{20{imm[11]}}, imm};
endfunction

// Expected ALU bundle, is_imm is set unless both operands come from registers
function automatic alu_ctrl_t expect_alu(input logic [3:0] sel, input logic op_a,
                                         input logic op_b, input logic use_pc,
                                         input logic [4:0] dest, input logic wb,
                                         input logic [31:0] imm);
  alu_ctrl_t a;
  a.alu_write = 1'b1;
  a.sel       = sel;
  a.op_a      = op_a;
  a.op_b      = op_b;
  a.use_pc    = use_pc;
  a.dest      = dest;
  a.wb        = wb;
  a.is_imm    = !(op_a && op_b);
  a.imm       = imm;
  return a;
endfunction

////////////////////
// Compare tasks

task automatic check_alu(input alu_ctrl_t got, input alu_ctrl_t exp, input string what);
  if (got !== exp) begin
    errors++;
    $display("ERR %0t: %s alu_ctrl got %h expected %h", $time, what, got, exp);
  end
endtask

task automatic check_rf(input rf_req_t got, input rf_req_t exp, input string what);
  if (got !== exp) begin
    errors++;
    $display("ERR %0t: %s rf_req got %h expected %h", $time, what, got, exp);
  end
endtask

task automatic check_lsu(input lsu_ctrl_t got, input lsu_ctrl_t exp, input string what);
  if (got !== exp) begin
    errors++;
    $display("ERR %0t: %s lsu_ctrl got %h expected %h", $time, what, got, exp);
  end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    errors++;
    $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
  end
endtask

task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
  if (got !== exp) begin
    errors++;
    $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
  end
endtask

task automatic check_count(input int got, input int exp, input string what);
  if (got != exp) begin
    errors++;
    $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
  end
endtask

`endif

/* tests/tb_rv32_decoder.sv */
// Directed testbench for the RV32I decoder that checks sequencing and registered control
`timescale 1ns/1ps

module tb_rv32_decoder
  import rv_isa_pkg::*;
  import decoder_pkg::*;
();

  localparam int CLK_PERIOD = 100;
  localparam int ALU_RUNS   = 24;
  // Reset, random ALU ops, upper, stall, load, store, JAL, illegal and invalid
  localparam int TEST_CYCLES = 12 + ALU_RUNS * 2 + 4 + 9 + 6 + 4 + 4 + 9;
  localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

  logic        clk_i;
  logic        rstn_i;
  instr_t      instr_i;
  logic [31:0] pc_i;
  logic        instr_valid_i;
  logic        ready_o;
  logic        jmp_o;
  logic [31:0] jmp_addr_o;
  alu_ctrl_t   alu_ctrl_o;
  rf_req_t     rf_req_o;
  lsu_ctrl_t   lsu_ctrl_o;
  logic        illegal_o;

  integer      seed = 77;
  int          errors = 0;
  int          cycles = 0;
  logic [4:0]  prev_rd;     // Destination of the last issued writing instruction

  `include "tb_checks.svh"

  rv32_decoder i_dut (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .instr_valid_i (instr_valid_i),
    .ready_o       (ready_o),
    .jmp_o         (jmp_o),
    .jmp_addr_o    (jmp_addr_o),
    .alu_ctrl_o    (alu_ctrl_o),
    .rf_req_o      (rf_req_o),
    .lsu_ctrl_o    (lsu_ctrl_o),
    .illegal_o     (illegal_o)
  );

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////
  // Drive helpers

  function automatic logic [31:0] rand_word();
    rand_word = $random(seed);
  endfunction

  function automatic logic [4:0] avoid_rd(input logic [4:0] r);
    return ((r == prev_rd) && (r != 5'd0)) ? (r ^ 5'd1) : r;
  endfunction

  task automatic present(input instr_t w, input logic [31:0] pc);
    @(posedge clk_i);
    instr_i       <= w;
    pc_i          <= pc;
    instr_valid_i <= 1'b1;
    @(negedge clk_i);
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    @(negedge clk_i);
  endtask

  task automatic go_idle();
    @(posedge clk_i);
    instr_valid_i <= 1'b0;
    instr_i       <= rand_word(); // Junk that must be ignored
    @(negedge clk_i);
  endtask

  // One single-cycle instruction followed by a check of its registered control
  task automatic run_single(input instr_t w, input alu_ctrl_t exp_alu,
                            input rf_req_t exp_rf, input string what);
    present(w, rand_word() & 32'hffff_fffc);
    check_bit(ready_o, 1'b1, {what, " ready"});
    go_idle();
    check_alu(alu_ctrl_o, exp_alu, what);
    check_rf(rf_req_o, exp_rf, what);
    check_lsu(lsu_ctrl_o, '0, what);
    check_bit(illegal_o, 1'b0, {what, " illegal"});
    prev_rd = exp_alu.wb ? exp_alu.dest : 5'd0;
  endtask

  ////////////////////
  // Directed tests

  task automatic test_alu_ops();
    logic [31:0] rnd;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic        b30;
    repeat (ALU_RUNS) begin
      rnd = rand_word();
      rd  = rnd[4:0];
      rs1 = avoid_rd(rnd[9:5]);
      rs2 = avoid_rd(rnd[14:10]);
      f3  = rnd[17:15];
      b30 = rnd[18];
      if (rnd[19]) begin
        run_single(build_r({1'b0, b30, 5'b0}, rs2, rs1, f3, rd, OPC_OP),
                   expect_alu({b30, f3}, 1'b1, 1'b1, 1'b0, rd, 1'b1, '0),
                   rf_req_t'{rs1, rs2}, "OP");
      end else if ((f3 == 3'b001) || (f3 == 3'b101)) begin
        // Zero-extended shift amount sits in the rs2 field
        run_single(build_r({1'b0, b30, 5'b0}, rs2, rs1, f3, rd, OPC_OPIMM),
                   expect_alu({b30, f3}, 1'b1, 1'b0, 1'b0, rd, 1'b1, {27'b0, rs2}),
                   rf_req_t'{rs1, 5'd0}, "OP-IMM shift");
      end else begin
        run_single(build_i(rnd[31:20], rs1, f3, rd, OPC_OPIMM),
                   expect_alu({1'b0, f3}, 1'b1, 1'b0, 1'b0, rd, 1'b1, sext12(rnd[31:20])),
                   rf_req_t'{rs1, 5'd0}, "OP-IMM");
      end
    end
  endtask

  task automatic test_upper();
    logic [31:0] rnd;
    rnd = rand_word();
    run_single(build_u(rnd[31:12], rnd[4:0], OPC_LUI),
               expect_alu(ALU_ADD, 1'b1, 1'b0, 1'b0, rnd[4:0], 1'b1, {rnd[31:12], 12'b0}),
               '0, "LUI");
    rnd = rand_word();
    run_single(build_u(rnd[31:12], rnd[4:0], OPC_AUIPC),
               expect_alu(ALU_ADD, 1'b1, 1'b0, 1'b1, rnd[4:0], 1'b1, {rnd[31:12], 12'b0}),
               '0, "AUIPC");
  endtask

  task automatic test_stall();
    logic [31:0] rnd;
    logic [4:0]  rd1;
    logic [4:0]  rd2;
    rnd = rand_word();
    rd1 = rnd[4:0] | 5'd1;
    rd2 = rnd[9:5];
    run_single(build_r(7'd0, avoid_rd(5'd3), avoid_rd(5'd2), 3'b000, rd1, OPC_OP),
               expect_alu(4'b0000, 1'b1, 1'b1, 1'b0, rd1, 1'b1, '0),
               rf_req_t'{avoid_rd(5'd2), avoid_rd(5'd3)}, "stall producer");
    present(build_i(rnd[21:10], rd1, 3'b000, rd2, OPC_OPIMM), 32'h100);
    check_bit(ready_o, 1'b0, "stall cycle ready");
    next_cycle();
    check_bit(ready_o, 1'b1, "after stall ready");
    check_bit(alu_ctrl_o.wb, 1'b0, "stall cycle writeback");
    go_idle();
    check_alu(alu_ctrl_o, expect_alu(ALU_ADD, 1'b1, 1'b0, 1'b0, rd2, 1'b1,
              sext12(rnd[21:10])), "stalled ADDI");
    prev_rd = rd2;
    // Writes to x0 never create a dependence
    run_single(build_r(7'd0, avoid_rd(5'd4), avoid_rd(5'd5), 3'b000, 5'd0, OPC_OP),
               expect_alu(4'b0000, 1'b1, 1'b1, 1'b0, 5'd0, 1'b1, '0),
               rf_req_t'{avoid_rd(5'd5), avoid_rd(5'd4)}, "write x0");
    run_single(build_r(7'd0, 5'd0, 5'd0, 3'b000, 5'd6, OPC_OP),
               expect_alu(4'b0000, 1'b1, 1'b1, 1'b0, 5'd6, 1'b1, '0),
               rf_req_t'{5'd0, 5'd0}, "read x0");
  endtask

  task automatic test_load_store();
    logic [31:0] rnd;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    int          waited;
    int          hits;
    rnd    = rand_word();
    rd     = rnd[4:0];
    rs1    = avoid_rd(rnd[9:5]);
    waited = 0;
    hits   = 0;
    present(build_i(rnd[31:20], rs1, rnd[12:10], rd, OPC_LOAD), 32'h200);
    while (ready_o !== 1'b1) begin
      next_cycle();
      waited++;
      if (lsu_ctrl_o.valid) begin
        hits++;
        check_lsu(lsu_ctrl_o, lsu_ctrl_t'{1'b1, {1'b0, rnd[12:10]}, rd}, "load issue");
      end
    end
    go_idle();
    if (lsu_ctrl_o.valid) hits++;
    check_count(waited, 4, "load cycles with ready low");
    check_count(hits, 1, "load lsu valid cycles");
    prev_rd = rd;
    rnd = rand_word();
    rs1 = avoid_rd(rnd[4:0]);
    rs2 = avoid_rd(rnd[9:5]);
    present(build_s(rnd[31:20], rs2, rs1, rnd[12:10]), 32'h300);
    check_bit(ready_o, 1'b0, "store address cycle ready");
    next_cycle();
    check_bit(ready_o, 1'b1, "store issue ready");
    go_idle();
    check_rf(rf_req_o, rf_req_t'{rs1, rs2}, "store issue");
    check_bit(alu_ctrl_o.op_b, 1'b1, "store operand B");
    check_lsu(lsu_ctrl_o, lsu_ctrl_t'{1'b1, {1'b1, rnd[12:10]}, 5'd0}, "store issue");
    go_idle();
    check_rf(rf_req_o, rf_req_t'{rs1, rs2}, "store idle hold");
    check_lsu(lsu_ctrl_o, lsu_ctrl_t'{1'b1, {1'b1, rnd[12:10]}, 5'd0}, "store idle hold");
    prev_rd = 5'd0;
  endtask

  task automatic test_jal();
    logic [31:0] rnd;
    logic [31:0] pc;
    logic [4:0]  rd;
    rnd = rand_word();
    pc  = rand_word() & 32'hffff_fffc;
    rd  = rnd[25:21] | 5'd1;
    present(build_j({rnd[19:0], 1'b0}, rd), pc);
    check_bit(jmp_o, 1'b1, "JAL jump pulse");
    check_word(jmp_addr_o, pc + {{11{rnd[19]}}, rnd[19:0], 1'b0}, "JAL target");
    check_bit(ready_o, 1'b0, "JAL cycle 0 ready");
    next_cycle();
    check_bit(jmp_o, 1'b0, "JAL pulse end");
    check_bit(ready_o, 1'b0, "JAL cycle 1 ready");
    check_alu(alu_ctrl_o, expect_alu(ALU_ADD, 1'b0, 1'b0, 1'b1, rd, 1'b1, 32'd4), "JAL link");
    next_cycle();
    check_bit(ready_o, 1'b1, "JAL cycle 2 ready");
    go_idle();
    prev_rd = rd;
  endtask

  task automatic test_illegal_invalid();
    alu_ctrl_t exp;
    present(build_r(7'd0, 5'd1, 5'd2, 3'b000, 5'd0, 7'b1100011), 32'h400); // BEQ
    go_idle();
    check_bit(illegal_o, 1'b1, "BRANCH illegal");
    present(build_r(7'd0, 5'd1, 5'd2, 3'b000, 5'd3, 7'b1111111), 32'h404);
    go_idle();
    check_bit(illegal_o, 1'b1, "unknown opcode illegal");
    present(build_i(12'd0, 5'd0, 3'b000, 5'd0, OPC_MISCMEM), 32'h408);
    check_bit(ready_o, 1'b1, "FENCE ready");
    go_idle();
    check_bit(illegal_o, 1'b0, "FENCE illegal");
    check_bit(alu_ctrl_o.wb, 1'b0, "FENCE writeback");
    prev_rd = 5'd0;
    exp = expect_alu(ALU_ADD, 1'b1, 1'b0, 1'b1, 5'd9, 1'b1, 32'h12345000);
    run_single(build_u(20'h12345, 5'd9, OPC_AUIPC), exp, '0, "AUIPC before idle");
    // A load left on the bus must not start a sequence
    @(posedge clk_i);
    instr_valid_i <= 1'b0;
    instr_i       <= build_i(12'h010, 5'd7, 3'b010, 5'd8, OPC_LOAD);
    @(negedge clk_i);
    exp.use_pc = 1'b0;
    check_bit(ready_o, 1'b1, "idle ready");
    check_alu(alu_ctrl_o, exp, "idle hold");
    check_rf(rf_req_o, '0, "idle hold");
    check_lsu(lsu_ctrl_o, '0, "idle hold");
  endtask

  initial begin
    rstn_i        = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    prev_rd       = 5'd0;
    repeat (10) @(posedge clk_i);
    rstn_i <= 1'b1;
    @(negedge clk_i);
    check_bit(alu_ctrl_o.alu_write, 1'b1, "reset ALU write");
    check_bit(alu_ctrl_o.wb, 1'b0, "reset writeback");
    check_bit(alu_ctrl_o.use_pc, 1'b0, "reset use_pc");
    check_bit(lsu_ctrl_o.valid, 1'b0, "reset lsu valid");
    check_bit(illegal_o, 1'b0, "reset illegal");
    check_bit(jmp_o, 1'b0, "reset jump");
    test_alu_ops();
    test_upper();
    test_stall();
    test_load_store();
    test_jal();
    test_illegal_invalid();
    $display("Tests finished with %0d errors", errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+include
logic/rv_isa_pkg.sv
logic/decoder_pkg.sv
logic/imm_gen.sv
logic/hazard_unit.sv
logic/wait_timer.sv
logic/decode_fsm.sv
logic/issue_regs.sv
logic/rv32_decoder.sv
tests/tb_rv32_decoder.sv

/* Makefile */
TOP := tb_rv32_decoder
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f compile.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "No result in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
